/* source/mips_id_pkg.sv */
`default_nettype none

package mips_id_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [5:0]            opcode_t;
  typedef logic [5:0]            funct_t;

  typedef enum logic [7:0] {
    ALU_NOP  = 8'h00,
    ALU_ADD  = 8'h01,
    ALU_SUB  = 8'h02,
    ALU_SLT  = 8'h03,
    ALU_SLTU = 8'h04,
    ALU_AND  = 8'h10,
    ALU_OR   = 8'h11,
    ALU_XOR  = 8'h12,
    ALU_NOR  = 8'h13,
    ALU_SLL  = 8'h20,
    ALU_SRL  = 8'h21,
    ALU_SRA  = 8'h22,
    ALU_LB   = 8'h30,
    ALU_LW   = 8'h31,
    ALU_SB   = 8'h38,
    ALU_SW   = 8'h39,
    ALU_JAL  = 8'h40  // link write of pc + 8
  } aluop_t;

  // primary opcodes
  localparam opcode_t OP_R      = 6'b000000;
  localparam opcode_t OP_REGIMM = 6'b000001;  // branch kind lives in rt
  localparam opcode_t OP_J      = 6'b000010;
  localparam opcode_t OP_JAL    = 6'b000011;
  localparam opcode_t OP_BEQ    = 6'b000100;
  localparam opcode_t OP_BNE    = 6'b000101;
  localparam opcode_t OP_BLEZ   = 6'b000110;
  localparam opcode_t OP_BGTZ   = 6'b000111;
  localparam opcode_t OP_ADDI   = 6'b001000;
  localparam opcode_t OP_ADDIU  = 6'b001001;
  localparam opcode_t OP_SLTI   = 6'b001010;
  localparam opcode_t OP_SLTIU  = 6'b001011;
  localparam opcode_t OP_ANDI   = 6'b001100;
  localparam opcode_t OP_ORI    = 6'b001101;
  localparam opcode_t OP_XORI   = 6'b001110;
  localparam opcode_t OP_LUI    = 6'b001111;
  localparam opcode_t OP_LB     = 6'b100000;
  localparam opcode_t OP_LW     = 6'b100011;
  localparam opcode_t OP_SB     = 6'b101000;
  localparam opcode_t OP_SW     = 6'b101011;

  // function field of OP_R
  localparam funct_t FN_SLL  = 6'b000000;
  localparam funct_t FN_SRL  = 6'b000010;
  localparam funct_t FN_SRA  = 6'b000011;
  localparam funct_t FN_SLLV = 6'b000100;
  localparam funct_t FN_SRLV = 6'b000110;
  localparam funct_t FN_SRAV = 6'b000111;
  localparam funct_t FN_JR   = 6'b001000;
  localparam funct_t FN_JALR = 6'b001001;
  localparam funct_t FN_ADD  = 6'b100000;
  localparam funct_t FN_ADDU = 6'b100001;
  localparam funct_t FN_SUB  = 6'b100010;
  localparam funct_t FN_SUBU = 6'b100011;
  localparam funct_t FN_AND  = 6'b100100;
  localparam funct_t FN_OR   = 6'b100101;
  localparam funct_t FN_XOR  = 6'b100110;
  localparam funct_t FN_NOR  = 6'b100111;
  localparam funct_t FN_SLT  = 6'b101010;
  localparam funct_t FN_SLTU = 6'b101011;

  // rt codes under OP_REGIMM
  localparam reg_addr_t RT_BLTZ   = 5'b00000;
  localparam reg_addr_t RT_BGEZ   = 5'b00001;
  localparam reg_addr_t RT_BLTZAL = 5'b10000;
  localparam reg_addr_t RT_BGEZAL = 5'b10001;

  localparam reg_addr_t LINK_REG = 5'd31;

endpackage

`default_nettype wire

/* source/regfile.sv */
`default_nettype none
`timescale 1ns/10ps

module regfile (
  input  wire                    clk,
  input  wire                    rst_n_i,
  input  wire                    we_i,
  input  wire mips_id_pkg::reg_addr_t waddr_i,
  input  wire mips_id_pkg::word_t     wdata_i,
  input  wire mips_id_pkg::reg_addr_t raddr1_i,
  input  wire mips_id_pkg::reg_addr_t raddr2_i,
  output mips_id_pkg::word_t     rdata1_o,
  output mips_id_pkg::word_t     rdata2_o
);
  import mips_id_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin  // r0 stays zero
      regs[waddr_i] <= wdata_i;
    end
  end

  // same-cycle write is seen by the reader
  assign rdata1_o = (raddr1_i == '0) ? '0 :
                    (we_i && (waddr_i == raddr1_i)) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 :
                    (we_i && (waddr_i == raddr2_i)) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

/* source/id_decoder.sv */
`default_nettype none
`timescale 1ns/10ps

module id_decoder (
  input  wire mips_id_pkg::word_t inst_i,
  output mips_id_pkg::aluop_t     aluop_o,
  output logic                    re1_o,
  output logic                    re2_o,
  output mips_id_pkg::reg_addr_t  raddr1_o,
  output mips_id_pkg::reg_addr_t  raddr2_o,
  output mips_id_pkg::reg_addr_t  waddr_o,
  output logic                    we_o,
  output mips_id_pkg::word_t      imm_o
);
  import mips_id_pkg::*;

  opcode_t   op;
  funct_t    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  reg_addr_t shamt;
  word_t     imm_s;
  word_t     imm_u;

  assign op    = inst_i[31:26];
  assign rs    = inst_i[25:21];
  assign rt    = inst_i[20:16];
  assign rd    = inst_i[15:11];
  assign shamt = inst_i[10:6];
  assign funct = inst_i[5:0];
  assign imm_s = {{16{inst_i[15]}}, inst_i[15:0]};
  assign imm_u = {16'h0000, inst_i[15:0]};

  always_comb begin
    aluop_o  = ALU_NOP;
    re1_o    = 1'b0;
    re2_o    = 1'b0;
    raddr1_o = rs;
    raddr2_o = rt;
    waddr_o  = rd;
    we_o     = 1'b0;
    imm_o    = '0;
    case (op)
      OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LB, OP_LW: begin
        re1_o   = 1'b1;
        we_o    = 1'b1;
        waddr_o = rt;
        imm_o   = imm_s;
        case (op)
          OP_SLTI:  aluop_o = ALU_SLT;
          OP_SLTIU: aluop_o = ALU_SLTU;
          OP_LB:    aluop_o = ALU_LB;
          OP_LW:    aluop_o = ALU_LW;
          default:  aluop_o = ALU_ADD;
        endcase
      end
      OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        re1_o   = 1'b1;  // rs is r0 for lui, so or gives the imm
        we_o    = 1'b1;
        waddr_o = rt;
        imm_o   = (op == OP_LUI) ? {inst_i[15:0], 16'h0000} : imm_u;
        case (op)
          OP_ANDI: aluop_o = ALU_AND;
          OP_XORI: aluop_o = ALU_XOR;
          default: aluop_o = ALU_OR;
        endcase
      end
      OP_SB, OP_SW: begin
        aluop_o = (op == OP_SB) ? ALU_SB : ALU_SW;
        re1_o   = 1'b1;
        re2_o   = 1'b1;
        imm_o   = imm_s;
      end
      OP_BEQ, OP_BNE: begin
        re1_o = 1'b1;
        re2_o = 1'b1;
      end
      OP_BGTZ, OP_BLEZ: re1_o = 1'b1;
      OP_JAL: begin
        aluop_o = ALU_JAL;
        we_o    = 1'b1;
        waddr_o = LINK_REG;
      end
      OP_REGIMM: begin
        re1_o = (rt == RT_BLTZ) || (rt == RT_BGEZ) || (rt == RT_BLTZAL) || (rt == RT_BGEZAL);
        if ((rt == RT_BLTZAL) || (rt == RT_BGEZAL)) begin
          aluop_o = ALU_JAL;  // we comes from the branch unit
          waddr_o = LINK_REG;
        end
      end
      OP_R: begin
        if (shamt == '0) begin
          re1_o = 1'b1;
          re2_o = 1'b1;
          we_o  = 1'b1;
          case (funct)
            FN_ADD, FN_ADDU: aluop_o = ALU_ADD;
            FN_SUB, FN_SUBU: aluop_o = ALU_SUB;
            FN_SLT:          aluop_o = ALU_SLT;
            FN_SLTU:         aluop_o = ALU_SLTU;
            FN_AND:          aluop_o = ALU_AND;
            FN_OR:           aluop_o = ALU_OR;
            FN_XOR:          aluop_o = ALU_XOR;
            FN_NOR:          aluop_o = ALU_NOR;
            FN_SLLV:         aluop_o = ALU_SLL;
            FN_SRLV:         aluop_o = ALU_SRL;
            FN_SRAV:         aluop_o = ALU_SRA;
            FN_JR: begin
              re2_o = 1'b0;
              we_o  = 1'b0;
            end
            FN_JALR: begin
              aluop_o = ALU_JAL;
              re2_o   = 1'b0;
            end
            default: begin
              re1_o = 1'b0;
              re2_o = 1'b0;
              we_o  = 1'b0;
            end
          endcase
        end else if ((rs == '0) &&
                     ((funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA))) begin
          // shift by constant, shamt goes in as operand 1
          re2_o   = 1'b1;
          we_o    = 1'b1;
          imm_o   = {27'd0, shamt};
          aluop_o = (funct == FN_SLL) ? ALU_SLL : (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
        end
      end
      default: begin
        // OP_J and unknown opcodes read and write nothing
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/operand_fwd.sv */
`default_nettype none
`timescale 1ns/10ps

module operand_fwd (
  input  wire                         re_i,
  input  wire mips_id_pkg::reg_addr_t raddr_i,
  input  wire mips_id_pkg::word_t     rf_data_i,
  input  wire mips_id_pkg::word_t     imm_i,
  input  wire                         ex_we_i,
  input  wire mips_id_pkg::reg_addr_t ex_waddr_i,
  input  wire mips_id_pkg::word_t     ex_wdata_i,
  input  wire mips_id_pkg::aluop_t    ex_aluop_i,
  input  wire                         mem_we_i,
  input  wire mips_id_pkg::reg_addr_t mem_waddr_i,
  input  wire mips_id_pkg::word_t     mem_wdata_i,
  output mips_id_pkg::word_t          opnd_o,
  output logic                        stall_o
);
  import mips_id_pkg::*;

  logic ex_hit;
  logic mem_hit;
  logic ex_is_load;

  assign ex_hit     = ex_we_i && (ex_waddr_i == raddr_i) && (raddr_i != '0);
  assign mem_hit    = mem_we_i && (mem_waddr_i == raddr_i) && (raddr_i != '0);
  assign ex_is_load = (ex_aluop_i == ALU_LB) || (ex_aluop_i == ALU_LW);

  // load data not ready until mem, so wait a cycle
  assign stall_o = re_i && ex_hit && ex_is_load;

  always_comb begin
    if (!re_i)        opnd_o = imm_i;
    else if (stall_o) opnd_o = '0;
    else if (ex_hit)  opnd_o = ex_wdata_i;   // youngest result first
    else if (mem_hit) opnd_o = mem_wdata_i;
    else              opnd_o = rf_data_i;
  end

endmodule

`default_nettype wire

/* source/branch_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module branch_unit (
  input  wire mips_id_pkg::word_t inst_i,
  input  wire mips_id_pkg::word_t pc_i,
  input  wire mips_id_pkg::word_t opnd1_i,
  input  wire mips_id_pkg::word_t opnd2_i,
  output logic                    taken_o,
  output mips_id_pkg::word_t      target_o,
  output mips_id_pkg::word_t      link_addr_o,
  output logic                    link_we_o
);
  import mips_id_pkg::*;

  opcode_t   op;
  funct_t    funct;
  reg_addr_t rt;
  word_t     next_pc;
  word_t     br_addr;
  word_t     jmp_addr;
  logic      neg;
  logic      zero;

  assign op       = inst_i[31:26];
  assign rt       = inst_i[20:16];
  assign funct    = inst_i[5:0];
  assign next_pc  = pc_i + 32'd4;
  assign br_addr  = next_pc + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
  assign jmp_addr = {next_pc[31:28], inst_i[25:0], 2'b00};
  assign neg      = opnd1_i[31];
  assign zero     = (opnd1_i == '0);

  always_comb begin
    taken_o   = 1'b0;
    target_o  = '0;
    link_we_o = 1'b0;
    case (op)
      OP_BEQ:  taken_o = (opnd1_i == opnd2_i);
      OP_BNE:  taken_o = (opnd1_i != opnd2_i);
      OP_BGTZ: taken_o = !neg && !zero;
      OP_BLEZ: taken_o = neg || zero;
      OP_J:    taken_o = 1'b1;
      OP_JAL: begin
        taken_o   = 1'b1;
        link_we_o = 1'b1;
      end
      OP_REGIMM: begin
        case (rt)
          RT_BLTZ:   taken_o = neg;
          RT_BGEZ:   taken_o = !neg;
          RT_BLTZAL: taken_o = neg;
          RT_BGEZAL: taken_o = !neg;
          default:   taken_o = 1'b0;
        endcase
        link_we_o = taken_o && rt[4];  // link forms only
      end
      OP_R: begin
        if ((inst_i[10:6] == 5'd0) && ((funct == FN_JR) || (funct == FN_JALR))) begin
          taken_o   = 1'b1;
          link_we_o = (funct == FN_JALR);
        end
      end
      default: taken_o = 1'b0;
    endcase
    if (taken_o) begin
      case (op)
        OP_J, OP_JAL: target_o = jmp_addr;
        OP_R:         target_o = opnd1_i;
        default:      target_o = br_addr;
      endcase
    end
  end

  assign link_addr_o = link_we_o ? next_pc + 32'd4 : '0;

endmodule

`default_nettype wire

/* source/id_ex_reg.sv */
`default_nettype none
`timescale 1ns/10ps

module id_ex_reg (
  input  wire                         clk,
  input  wire                         rst_n_i,
  input  wire                         bubble_i,
  input  wire mips_id_pkg::aluop_t    aluop_i,
  input  wire mips_id_pkg::word_t     opnd1_i,
  input  wire mips_id_pkg::word_t     opnd2_i,
  input  wire mips_id_pkg::reg_addr_t waddr_i,
  input  wire                         we_i,
  input  wire mips_id_pkg::word_t     link_addr_i,
  output mips_id_pkg::aluop_t         aluop_o,
  output mips_id_pkg::word_t          opnd1_o,
  output mips_id_pkg::word_t          opnd2_o,
  output mips_id_pkg::reg_addr_t      waddr_o,
  output logic                        we_o,
  output mips_id_pkg::word_t          link_addr_o
);
  import mips_id_pkg::*;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aluop_o     <= ALU_NOP;
      opnd1_o     <= '0;
      opnd2_o     <= '0;
      waddr_o     <= '0;
      we_o        <= 1'b0;
      link_addr_o <= '0;
    end else if (bubble_i) begin  // insert nop, ex sees nothing
      aluop_o     <= ALU_NOP;
      opnd1_o     <= '0;
      opnd2_o     <= '0;
      waddr_o     <= '0;
      we_o        <= 1'b0;
      link_addr_o <= '0;
    end else begin
      aluop_o     <= aluop_i;
      opnd1_o     <= opnd1_i;
      opnd2_o     <= opnd2_i;
      waddr_o     <= waddr_i;
      we_o        <= we_i;
      link_addr_o <= link_addr_i;
    end
  end

endmodule

`default_nettype wire

/* source/id_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module id_stage (
  input  wire                         clk,
  input  wire                         rst_n_i,
  input  wire mips_id_pkg::word_t     pc_i,
  input  wire mips_id_pkg::word_t     inst_i,
  input  wire                         ex_we_i,
  input  wire mips_id_pkg::reg_addr_t ex_waddr_i,
  input  wire mips_id_pkg::word_t     ex_wdata_i,
  input  wire mips_id_pkg::aluop_t    ex_aluop_i,
  input  wire                         mem_we_i,
  input  wire mips_id_pkg::reg_addr_t mem_waddr_i,
  input  wire mips_id_pkg::word_t     mem_wdata_i,
  input  wire                         wb_we_i,
  input  wire mips_id_pkg::reg_addr_t wb_waddr_i,
  input  wire mips_id_pkg::word_t     wb_wdata_i,
  output mips_id_pkg::aluop_t         ex_aluop_o,
  output mips_id_pkg::word_t          ex_opnd1_o,
  output mips_id_pkg::word_t          ex_opnd2_o,
  output mips_id_pkg::reg_addr_t      ex_waddr_o,
  output logic                        ex_we_o,
  output mips_id_pkg::word_t          ex_link_addr_o,
  output logic                        branch_flag_o,
  output mips_id_pkg::word_t          branch_target_o,
  output logic                        stall_o
);
  import mips_id_pkg::*;

  aluop_t    dec_aluop;
  logic      re1;
  logic      re2;
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  reg_addr_t dec_waddr;
  logic      dec_we;
  word_t     imm;
  word_t     rf_data1;
  word_t     rf_data2;
  word_t     opnd1;
  word_t     opnd2;
  logic      stall1;
  logic      stall2;
  word_t     link_addr;
  logic      link_we;

  regfile u_regfile (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .we_i     (wb_we_i),
    .waddr_i  (wb_waddr_i),
    .wdata_i  (wb_wdata_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rf_data1),
    .rdata2_o (rf_data2)
  );

  id_decoder u_decoder (
    .inst_i   (inst_i),
    .aluop_o  (dec_aluop),
    .re1_o    (re1),
    .re2_o    (re2),
    .raddr1_o (raddr1),
    .raddr2_o (raddr2),
    .waddr_o  (dec_waddr),
    .we_o     (dec_we),
    .imm_o    (imm)
  );

  operand_fwd op1_fwd (
    .re_i        (re1),
    .raddr_i     (raddr1),
    .rf_data_i   (rf_data1),
    .imm_i       (imm),
    .ex_we_i     (ex_we_i),
    .ex_waddr_i  (ex_waddr_i),
    .ex_wdata_i  (ex_wdata_i),
    .ex_aluop_i  (ex_aluop_i),
    .mem_we_i    (mem_we_i),
    .mem_waddr_i (mem_waddr_i),
    .mem_wdata_i (mem_wdata_i),
    .opnd_o      (opnd1),
    .stall_o     (stall1)
  );

  operand_fwd op2_fwd (
    .re_i        (re2),
    .raddr_i     (raddr2),
    .rf_data_i   (rf_data2),
    .imm_i       (imm),
    .ex_we_i     (ex_we_i),
    .ex_waddr_i  (ex_waddr_i),
    .ex_wdata_i  (ex_wdata_i),
    .ex_aluop_i  (ex_aluop_i),
    .mem_we_i    (mem_we_i),
    .mem_waddr_i (mem_waddr_i),
    .mem_wdata_i (mem_wdata_i),
    .opnd_o      (opnd2),
    .stall_o     (stall2)
  );

  branch_unit u_branch (
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .opnd1_i     (opnd1),
    .opnd2_i     (opnd2),
    .taken_o     (branch_flag_o),
    .target_o    (branch_target_o),
    .link_addr_o (link_addr),
    .link_we_o   (link_we)
  );

  assign stall_o = stall1 | stall2;

  // conditional links only write when taken
  id_ex_reg u_id_ex (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .bubble_i    (stall_o),
    .aluop_i     (dec_aluop),
    .opnd1_i     (opnd1),
    .opnd2_i     (opnd2),
    .waddr_i     (dec_waddr),
    .we_i        (dec_we | link_we),
    .link_addr_i (link_addr),
    .aluop_o     (ex_aluop_o),
    .opnd1_o     (ex_opnd1_o),
    .opnd2_o     (ex_opnd2_o),
    .waddr_o     (ex_waddr_o),
    .we_o        (ex_we_o),
    .link_addr_o (ex_link_addr_o)
  );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #2 clk_o = ~clk_o;  // 4 ns period

endmodule

`default_nettype wire

/* verif/id_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage_tb;
  import mips_id_pkg::*;

  localparam int N_TESTS    = 2000;
  localparam int MAX_CYCLES = 10 + 2 * N_TESTS + 50;
  localparam logic [31:0] SEED = 32'h2703_7068;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZ,
    BR_LTZAL, BR_GEZAL, BR_J, BR_JAL, BR_JR, BR_JALR
  } br_kind_t;

  // expected decode of one instruction
  typedef struct packed {
    aluop_t    aluop;
    logic      re1;
    logic      re2;
    logic      chk1;  // operand carries data worth checking
    logic      chk2;
    word_t     imm;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t waddr;
    logic      we;
    br_kind_t  br;
  } dec_t;

  logic      clk;
  logic      rst_n;
  word_t     pc;
  word_t     inst;
  logic      ex_we;
  reg_addr_t ex_waddr;
  word_t     ex_wdata;
  aluop_t    ex_aluop;
  logic      mem_we;
  reg_addr_t mem_waddr;
  word_t     mem_wdata;
  logic      wb_we;
  reg_addr_t wb_waddr;
  word_t     wb_wdata;
  aluop_t    q_aluop;
  word_t     q_opnd1;
  word_t     q_opnd2;
  reg_addr_t q_waddr;
  logic      q_we;
  word_t     q_link;
  logic      br_flag;
  word_t     br_target;
  logic      stall;

  word_t shadow_rf [NUM_REGS];
  dec_t  cur_dec;
  dec_t  pend_dec;
  logic  pend_valid;
  logic  pend_bubble;
  logic  pend_we;
  logic  pend_link;
  word_t pend_o1;
  word_t pend_o2;
  word_t pend_link_addr;
  logic  exp_stall;
  int    cycle_cnt = 0;

  opcode_t i_op [12] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
                         OP_LUI, OP_LB, OP_LW, OP_SB, OP_SW};
  aluop_t  i_alu [12] = '{ALU_ADD, ALU_ADD, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
                          ALU_OR, ALU_LB, ALU_LW, ALU_SB, ALU_SW};
  funct_t  r_fn [13] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_AND, FN_OR,
                         FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV};
  aluop_t  r_alu [13] = '{ALU_ADD, ALU_ADD, ALU_SUB, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
                          ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA};
  funct_t    s_fn [3] = '{FN_SLL, FN_SRL, FN_SRA};
  aluop_t    s_alu [3] = '{ALU_SLL, ALU_SRL, ALU_SRA};
  reg_addr_t rim_rt [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
  br_kind_t  rim_br [4] = '{BR_LTZ, BR_GEZ, BR_LTZAL, BR_GEZAL};

  tb_clk_gen u_clk (.clk_o(clk));

  id_stage dut (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .pc_i            (pc),
    .inst_i          (inst),
    .ex_we_i         (ex_we),
    .ex_waddr_i      (ex_waddr),
    .ex_wdata_i      (ex_wdata),
    .ex_aluop_i      (ex_aluop),
    .mem_we_i        (mem_we),
    .mem_waddr_i     (mem_waddr),
    .mem_wdata_i     (mem_wdata),
    .wb_we_i         (wb_we),
    .wb_waddr_i      (wb_waddr),
    .wb_wdata_i      (wb_wdata),
    .ex_aluop_o      (q_aluop),
    .ex_opnd1_o      (q_opnd1),
    .ex_opnd2_o      (q_opnd2),
    .ex_waddr_o      (q_waddr),
    .ex_we_o         (q_we),
    .ex_link_addr_o  (q_link),
    .branch_flag_o   (br_flag),
    .branch_target_o (br_target),
    .stall_o         (stall)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Simulation FAILED");
      $fatal(1, "run timed out after %0d cycles", cycle_cnt);
    end
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "wrong value on %s", what);
    end
  endtask

  task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "wrong value on %s", what);
    end
  endtask

  task automatic check_aluop(input string what, input aluop_t got, input aluop_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %s (%h), expected %s", $time, what, got.name(), got,
               exp.name());
      $display("Simulation FAILED");
      $fatal(1, "wrong value on %s", what);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "wrong value on %s", what);
    end
  endtask

  function automatic word_t rand_data();
    int unsigned r;
    r = $urandom_range(0, 3);
    if (r == 0) return '0;  // zero and negative hit the sign tests
    if (r == 1) return $urandom | 32'h8000_0000;
    return $urandom;
  endfunction

  function automatic word_t rf_value(input reg_addr_t a);
    if (a == '0) return '0;
    if (wb_we && (wb_waddr == a)) return wb_wdata;  // write-through
    return shadow_rf[a];
  endfunction

  function automatic logic load_hit(input reg_addr_t a);
    return ex_we && (ex_waddr == a) && (a != '0) &&
           ((ex_aluop == ALU_LB) || (ex_aluop == ALU_LW));
  endfunction

  function automatic word_t fwd_value(input reg_addr_t a);
    if ((a != '0) && ex_we && (ex_waddr == a)) return ex_wdata;
    if ((a != '0) && mem_we && (mem_waddr == a)) return mem_wdata;
    return rf_value(a);
  endfunction

  task automatic branch_model(input dec_t d, input word_t o1, input word_t o2,
                              output logic taken, output word_t tgt, output logic link);
    word_t npc;
    word_t off;
    npc = pc + 32'd4;
    off = {{16{inst[15]}}, inst[15:0]};  // offset in words
    case (d.br)
      BR_EQ:             taken = (o1 == o2);
      BR_NE:             taken = (o1 != o2);
      BR_GTZ:            taken = ($signed(o1) > 0);
      BR_LEZ:            taken = ($signed(o1) <= 0);
      BR_LTZ, BR_LTZAL:  taken = ($signed(o1) < 0);
      BR_GEZ, BR_GEZAL:  taken = ($signed(o1) >= 0);
      BR_NONE:           taken = 1'b0;
      default:           taken = 1'b1;
    endcase
    if ((d.br == BR_J) || (d.br == BR_JAL)) begin
      tgt = (npc & 32'hF000_0000) | (word_t'(inst[25:0]) << 2);
    end else if ((d.br == BR_JR) || (d.br == BR_JALR)) begin
      tgt = o1;
    end else begin
      tgt = npc + off * 4;
    end
    link = (d.br == BR_JAL) || (d.br == BR_JALR) ||
           (((d.br == BR_LTZAL) || (d.br == BR_GEZAL)) && taken);
  endtask

  task automatic new_inst();
    dec_t        d;
    word_t       ins;
    word_t       pc_rand;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    reg_addr_t   sh;
    logic [15:0] im;
    int          kind;
    int          k;
    rs   = 5'($urandom_range(0, 7));
    rt   = 5'($urandom_range(0, 7));
    rd   = 5'($urandom_range(0, 7));
    sh   = 5'($urandom_range(1, 31));
    im   = 16'($urandom);
    k    = $urandom_range(0, 12);
    kind = $urandom_range(0, 23);
    if (kind == 7) rs = '0;  // lui has rs zero
    d       = '0;
    d.aluop = ALU_NOP;
    d.br    = BR_NONE;
    d.rs    = rs;
    d.rt    = rt;
    case (kind)
      0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11: begin
        ins     = {i_op[kind], rs, rt, im};
        d.aluop = i_alu[kind];
        d.re1   = 1'b1;
        d.chk1  = 1'b1;
        d.chk2  = 1'b1;
        if (kind >= 10) begin
          d.re2 = 1'b1;  // stores read both
        end else begin
          d.we    = 1'b1;
          d.waddr = rt;
          if (kind == 7) d.imm = {im, 16'h0000};
          else if ((kind >= 4) && (kind <= 6)) d.imm = {16'h0000, im};  // logic ops
          else d.imm = {{16{im[15]}}, im};
        end
      end
      12: begin
        ins = {OP_R, rs, rt, rd, 5'd0, r_fn[k]};
        d.aluop = r_alu[k];
        d.re1   = 1'b1;
        d.re2   = 1'b1;
        d.chk1  = 1'b1;
        d.chk2  = 1'b1;
        d.we    = 1'b1;
        d.waddr = rd;
      end
      13: begin
        ins = {OP_R, 5'd0, rt, rd, sh, s_fn[k % 3]};
        d.aluop = s_alu[k % 3];
        d.re2   = 1'b1;
        d.chk1  = 1'b1;  // shamt as operand 1
        d.chk2  = 1'b1;
        d.imm   = {27'd0, sh};
        d.we    = 1'b1;
        d.waddr = rd;
      end
      14, 15: begin
        ins = {(kind == 14) ? OP_BEQ : OP_BNE, rs, rt, im};
        d.re1  = 1'b1;
        d.re2  = 1'b1;
        d.chk1 = 1'b1;
        d.chk2 = 1'b1;
        d.br   = (kind == 14) ? BR_EQ : BR_NE;
      end
      16, 17: begin
        ins = {(kind == 16) ? OP_BGTZ : OP_BLEZ, rs, 5'd0, im};
        d.re1  = 1'b1;
        d.chk1 = 1'b1;
        d.br   = (kind == 16) ? BR_GTZ : BR_LEZ;
      end
      18: begin
        ins = {OP_REGIMM, rs, rim_rt[k % 4], im};
        d.re1  = 1'b1;
        d.chk1 = 1'b1;
        d.br   = rim_br[k % 4];
        if (k % 4 >= 2) begin
          d.aluop = ALU_JAL;
          d.waddr = LINK_REG;
        end
      end
      19: begin
        ins  = {OP_J, 26'($urandom)};
        d.br = BR_J;
      end
      20: begin
        ins = {OP_JAL, 26'($urandom)};
        d.aluop = ALU_JAL;
        d.we    = 1'b1;
        d.waddr = LINK_REG;
        d.br    = BR_JAL;
      end
      21: begin
        ins = {OP_R, rs, 10'd0, 5'd0, FN_JR};
        d.re1  = 1'b1;
        d.chk1 = 1'b1;
        d.br   = BR_JR;
      end
      22: begin
        ins = {OP_R, rs, 5'd0, rd, 5'd0, FN_JALR};
        d.aluop = ALU_JAL;
        d.re1   = 1'b1;
        d.chk1  = 1'b1;
        d.we    = 1'b1;
        d.waddr = rd;
        d.br    = BR_JALR;
      end
      default: ins = {6'b111111, 26'($urandom)};  // unknown opcode
    endcase
    pc_rand = $urandom;
    cur_dec = d;
    inst   <= ins;
    pc     <= {pc_rand[31:2], 2'b00};
  endtask

  task automatic drive_side_inputs();
    int unsigned r;
    r = $urandom_range(0, 7);
    ex_we    <= 1'($urandom_range(0, 1));
    ex_waddr <= 5'($urandom_range(0, 7));
    ex_wdata <= rand_data();
    case (r)
      0:       ex_aluop <= ALU_LB;
      1:       ex_aluop <= ALU_LW;
      2:       ex_aluop <= ALU_SUB;
      default: ex_aluop <= ALU_ADD;
    endcase
    mem_we    <= 1'($urandom_range(0, 1));
    mem_waddr <= 5'($urandom_range(0, 7));
    mem_wdata <= rand_data();
    wb_we     <= 1'($urandom_range(0, 1));
    wb_waddr  <= 5'($urandom_range(0, 7));
    wb_wdata  <= rand_data();
  endtask

  task automatic check_bubble(input string where);
    check_aluop({where, " ex_aluop_o"}, q_aluop, ALU_NOP);
    check_bit({where, " ex_we_o"}, q_we, 1'b0);
    check_addr({where, " ex_waddr_o"}, q_waddr, '0);
    check_word({where, " ex_opnd1_o"}, q_opnd1, '0);
    check_word({where, " ex_opnd2_o"}, q_opnd2, '0);
    check_word({where, " ex_link_addr_o"}, q_link, '0);
  endtask

  task automatic check_registered();
    if (pend_bubble) begin
      check_bubble("bubble");
    end else begin
      check_aluop("ex_aluop_o", q_aluop, pend_dec.aluop);
      check_bit("ex_we_o", q_we, pend_we);
      if (pend_we) check_addr("ex_waddr_o", q_waddr, pend_dec.waddr);
      if (pend_dec.chk1) check_word("ex_opnd1_o", q_opnd1, pend_o1);
      if (pend_dec.chk2) check_word("ex_opnd2_o", q_opnd2, pend_o2);
      if (pend_link) check_word("ex_link_addr_o", q_link, pend_link_addr);
    end
  endtask

  task automatic evaluate();
    word_t o1;
    word_t o2;
    word_t tgt;
    logic  st;
    logic  taken;
    logic  link;
    st = (cur_dec.re1 && load_hit(cur_dec.rs)) || (cur_dec.re2 && load_hit(cur_dec.rt));
    o1 = cur_dec.re1 ? fwd_value(cur_dec.rs) : cur_dec.imm;
    o2 = cur_dec.re2 ? fwd_value(cur_dec.rt) : cur_dec.imm;
    branch_model(cur_dec, o1, o2, taken, tgt, link);
    check_bit("stall_o", stall, st);
    if (!st) begin  // branch result unused while stalled
      check_bit("branch_flag_o", br_flag, taken);
      if (taken) check_word("branch_target_o", br_target, tgt);
    end
    pend_valid     = 1'b1;
    pend_bubble    = st;
    pend_dec       = cur_dec;
    pend_o1        = o1;
    pend_o2        = o2;
    pend_link      = link;
    pend_we        = cur_dec.we | link;
    pend_link_addr = pc + 32'd8;
    exp_stall      = st;
  endtask

  initial begin
    int n_done;
    void'($urandom(SEED));
    rst_n     = 1'b0;
    pc        = '0;
    inst      = '0;
    ex_we     = 1'b0;
    ex_waddr  = '0;
    ex_wdata  = '0;
    ex_aluop  = ALU_NOP;
    mem_we    = 1'b0;
    mem_waddr = '0;
    mem_wdata = '0;
    wb_we     = 1'b0;
    wb_waddr  = '0;
    wb_wdata  = '0;
    pend_valid = 1'b0;
    exp_stall  = 1'b0;
    n_done     = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow_rf[i] = '0;
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bubble("reset");
    check_bit("stall_o after reset", stall, 1'b0);  // inst is a nop here
    check_bit("branch_flag_o after reset", br_flag, 1'b0);

    @(posedge clk);
    new_inst();
    drive_side_inputs();
    while (n_done < N_TESTS) begin
      @(negedge clk);
      if (pend_valid) check_registered();
      evaluate();
      if (!exp_stall) n_done++;
      @(posedge clk);
      if (wb_we && (wb_waddr != '0)) shadow_rf[wb_waddr] = wb_wdata;
      if (!exp_stall) new_inst();  // fetch holds on stall
      drive_side_inputs();
    end
    @(negedge clk);
    check_registered();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
source/mips_id_pkg.sv
source/regfile.sv
source/id_decoder.sv
source/operand_fwd.sv
source/branch_unit.sv
source/id_ex_reg.sv
source/id_stage.sv
verif/tb_clk_gen.sv
verif/id_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := id_stage_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the binary is the test result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
